// File: common/rv_core_pkg.sv
// ==========================================================================
// RV32I core shared definitions
// Data and register-index types, major opcodes, ALU operations, branch
// conditions, operand selects and the reset fetch address
// ==========================================================================

package rv_core_pkg;

    // Machine word width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // First fetch address out of reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU operation, COPY_B passes operand B straight through
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_COPY_B
    } alu_op_t;

    // Conditional branch kind, NONE for everything that is not a branch
    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_NONE
    } branch_t;

    // Operand A source
    typedef enum logic [1:0] {
        A_RS1,
        A_PC,
        A_ZERO
    } a_sel_t;

    // Operand B source
    typedef enum logic [1:0] {
        B_RS2,
        B_IMM,
        B_FOUR
    } b_sel_t;

endpackage

// File: logic/reg_file.sv
// ==========================================================================
// Register file
// 32 x 32-bit integer registers, x0 hard-wired to zero.
// Two combinational read ports and one clocked write port.
// ==========================================================================

`timescale 1ns/1ns

module reg_file (
    input  logic                  CLK,
    input  logic                  nRST,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    output rv_core_pkg::word_t    rs1_data,
    output rv_core_pkg::word_t    rs2_data,
    input  logic                  wen,
    input  rv_core_pkg::reg_idx_t rd,
    input  rv_core_pkg::word_t    wdata
);

    rv_core_pkg::word_t regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // No bypass here, execute forwards the pending write itself
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: execute/alu.sv
// ==========================================================================
// ALU
// RV32I add, subtract, logic, shift and set-less-than operations, plus a
// pass-through of operand B
// ==========================================================================

`timescale 1ns/1ns

module alu (
    input  rv_core_pkg::alu_op_t op,
    input  rv_core_pkg::word_t   a,
    input  rv_core_pkg::word_t   b,
    output rv_core_pkg::word_t   result
);

    logic [4:0] shamt;

    // Shift amount is the low five bits only
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_core_pkg::ALU_ADD:  result = a + b;
            rv_core_pkg::ALU_SUB:  result = a - b;
            rv_core_pkg::ALU_SLL:  result = a << shamt;
            // Compare results are zero-extended flags
            rv_core_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            rv_core_pkg::ALU_SLTU: result = {31'b0, a < b};
            rv_core_pkg::ALU_XOR:  result = a ^ b;
            rv_core_pkg::ALU_SRL:  result = a >> shamt;
            // Arithmetic shift keeps the sign
            rv_core_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv_core_pkg::ALU_OR:   result = a | b;
            rv_core_pkg::ALU_AND:  result = a & b;
            default:               result = b;
        endcase
    end

endmodule

// File: execute/control_unit.sv
// ==========================================================================
// Control unit
// Combinational RV32I decoder. Produces register indices, the immediate,
// operand selects, ALU operation, branch kind, jump flags, write enable
// and an illegal flag for anything outside the supported set.
// ==========================================================================

`timescale 1ns/1ns

module control_unit (
    input  rv_core_pkg::word_t    instr,
    output rv_core_pkg::reg_idx_t rs1,
    output rv_core_pkg::reg_idx_t rs2,
    output rv_core_pkg::reg_idx_t rd,
    output rv_core_pkg::word_t    imm,
    output rv_core_pkg::a_sel_t   a_sel,
    output rv_core_pkg::b_sel_t   b_sel,
    output rv_core_pkg::alu_op_t  alu_op,
    output rv_core_pkg::branch_t  branch_type,
    output logic                  jump,
    output logic                  jalr,
    output logic                  wen,
    output logic                  illegal
);

    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    rv_core_pkg::word_t imm_i, imm_b, imm_u, imm_j;
    rv_core_pkg::alu_op_t funct_op;
    logic alt, funct_bad;
    logic writes;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // Sign-extended immediates per format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct7 bit 5 picks SUB and SRA
    assign alt = funct7[5];

    // funct3 to ALU op, shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  funct_op = rv_core_pkg::ALU_ADD;
            3'b001:  funct_op = rv_core_pkg::ALU_SLL;
            3'b010:  funct_op = rv_core_pkg::ALU_SLT;
            3'b011:  funct_op = rv_core_pkg::ALU_SLTU;
            3'b100:  funct_op = rv_core_pkg::ALU_XOR;
            3'b101:  funct_op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  funct_op = rv_core_pkg::ALU_OR;
            default: funct_op = rv_core_pkg::ALU_AND;
        endcase
    end

    // Only 0000000, or 0100000 on the alternate slot, is a valid funct7
    always_comb begin
        funct_bad = !(funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b101));
        if (opcode == rv_core_pkg::OPC_OP && funct3 == 3'b000) begin
            funct_bad = !(funct7 == 7'b0000000 || funct7 == 7'b0100000);
        end
    end

    always_comb begin
        // Defaults decode LUI: zero plus B
        imm         = imm_u;
        a_sel       = rv_core_pkg::A_ZERO;
        b_sel       = rv_core_pkg::B_IMM;
        alu_op      = rv_core_pkg::ALU_COPY_B;
        branch_type = rv_core_pkg::BR_NONE;
        jump        = 1'b0;
        jalr        = 1'b0;
        writes      = 1'b0;
        illegal     = 1'b0;
        case (opcode)
            rv_core_pkg::OPC_LUI: begin
                writes = 1'b1;
            end
            rv_core_pkg::OPC_AUIPC: begin
                a_sel  = rv_core_pkg::A_PC;
                alu_op = rv_core_pkg::ALU_ADD;
                writes = 1'b1;
            end
            rv_core_pkg::OPC_JAL: begin
                // Link value PC+4 comes out of the ALU
                imm    = imm_j;
                a_sel  = rv_core_pkg::A_PC;
                b_sel  = rv_core_pkg::B_FOUR;
                alu_op = rv_core_pkg::ALU_ADD;
                jump   = 1'b1;
                writes = 1'b1;
            end
            rv_core_pkg::OPC_JALR: begin
                imm     = imm_i;
                a_sel   = rv_core_pkg::A_PC;
                b_sel   = rv_core_pkg::B_FOUR;
                alu_op  = rv_core_pkg::ALU_ADD;
                jalr    = 1'b1;
                writes  = 1'b1;
                illegal = funct3 != 3'b000;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000:  branch_type = rv_core_pkg::BR_BEQ;
                    3'b001:  branch_type = rv_core_pkg::BR_BNE;
                    3'b100:  branch_type = rv_core_pkg::BR_BLT;
                    3'b101:  branch_type = rv_core_pkg::BR_BGE;
                    3'b110:  branch_type = rv_core_pkg::BR_BLTU;
                    3'b111:  branch_type = rv_core_pkg::BR_BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            rv_core_pkg::OPC_OP_IMM: begin
                imm    = imm_i;
                a_sel  = rv_core_pkg::A_RS1;
                alu_op = funct_op;
                writes = 1'b1;
                // funct7 is part of the immediate except on shifts
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    illegal = funct_bad;
                end
            end
            rv_core_pkg::OPC_OP: begin
                a_sel   = rv_core_pkg::A_RS1;
                b_sel   = rv_core_pkg::B_RS2;
                alu_op  = (funct3 == 3'b000 && alt) ? rv_core_pkg::ALU_SUB : funct_op;
                writes  = 1'b1;
                illegal = funct_bad;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

    // x0 destination never counts as a write
    assign wen = writes && (rd != 5'd0);

endmodule

// File: execute/execute_stage.sv
// ==========================================================================
// Execute stage
// Decodes the fetched instruction, reads registers with forwarding from
// writeback, runs the ALU, resolves branches and jumps, and loads the
// execute-to-writeback register that feeds the register file and the
// retire port
// ==========================================================================

`timescale 1ns/1ns

module execute_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  run,
    input  logic                  fe_valid,
    input  rv_core_pkg::word_t    fe_pc,
    input  rv_core_pkg::word_t    fe_instr,
    output logic                  redirect,
    output rv_core_pkg::word_t    redirect_pc,
    output logic                  retire_valid,
    output rv_core_pkg::word_t    retire_pc,
    output logic                  retire_wen,
    output rv_core_pkg::reg_idx_t retire_rd,
    output rv_core_pkg::word_t    retire_data,
    output logic                  retire_illegal
);

    // Decode outputs
    rv_core_pkg::reg_idx_t rs1, rs2, rd;
    rv_core_pkg::word_t    imm;
    rv_core_pkg::a_sel_t   a_sel;
    rv_core_pkg::b_sel_t   b_sel;
    rv_core_pkg::alu_op_t  alu_op;
    rv_core_pkg::branch_t  branch_type;
    logic                  jump, jalr, wen, illegal;

    // Operands and results
    rv_core_pkg::word_t rs1_data, rs2_data;
    rv_core_pkg::word_t rs1_val, rs2_val;
    rv_core_pkg::word_t op_a, op_b, alu_result;
    rv_core_pkg::word_t br_target, jalr_target;
    logic               branch_taken;

    // Writeback register
    logic                  wb_valid, wb_wen, wb_illegal;
    rv_core_pkg::word_t    wb_pc, wb_data;
    rv_core_pkg::reg_idx_t wb_rd;

    control_unit u_control (
        .instr(fe_instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .a_sel(a_sel), .b_sel(b_sel), .alu_op(alu_op),
        .branch_type(branch_type), .jump(jump), .jalr(jalr),
        .wen(wen), .illegal(illegal)
    );

    // Write happens on the edge that ends the retire cycle
    reg_file u_reg_file (
        .CLK(CLK), .nRST(nRST), .rs1(rs1), .rs2(rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wen(wb_wen && run), .rd(wb_rd), .wdata(wb_data)
    );

    // wb_wen is never set for x0, so a match means a real pending write
    assign rs1_val = (wb_wen && wb_rd == rs1) ? wb_data : rs1_data;
    assign rs2_val = (wb_wen && wb_rd == rs2) ? wb_data : rs2_data;

    always_comb begin
        case (a_sel)
            rv_core_pkg::A_RS1: op_a = rs1_val;
            rv_core_pkg::A_PC:  op_a = fe_pc;
            default:            op_a = '0;
        endcase
        case (b_sel)
            rv_core_pkg::B_RS2: op_b = rs2_val;
            rv_core_pkg::B_IMM: op_b = imm;
            default:            op_b = 32'd4;
        endcase
    end

    alu u_alu (.op(alu_op), .a(op_a), .b(op_b), .result(alu_result));

    // Branch condition on forwarded values
    always_comb begin
        case (branch_type)
            rv_core_pkg::BR_BEQ:  branch_taken = rs1_val == rs2_val;
            rv_core_pkg::BR_BNE:  branch_taken = rs1_val != rs2_val;
            rv_core_pkg::BR_BLT:  branch_taken = $signed(rs1_val) < $signed(rs2_val);
            rv_core_pkg::BR_BGE:  branch_taken = $signed(rs1_val) >= $signed(rs2_val);
            rv_core_pkg::BR_BLTU: branch_taken = rs1_val < rs2_val;
            rv_core_pkg::BR_BGEU: branch_taken = rs1_val >= rs2_val;
            default:              branch_taken = 1'b0;
        endcase
    end

    // Branches and JAL are PC relative, JALR drops bit 0
    assign br_target   = fe_pc + imm;
    assign jalr_target = (rs1_val + imm) & ~32'd1;

    assign redirect    = fe_valid && !illegal && (jump || jalr || branch_taken);
    assign redirect_pc = jalr ? jalr_target : br_target;

    // Control bits, illegal keeps its flag but never writes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wb_valid   <= 1'b0;
            wb_wen     <= 1'b0;
            wb_illegal <= 1'b0;
        end else if (run) begin
            wb_valid   <= fe_valid;
            wb_wen     <= fe_valid && wen && !illegal;
            wb_illegal <= fe_valid && illegal;
        end
    end

    // Payload
    always_ff @(posedge CLK) begin
        if (run) begin
            wb_pc   <= fe_pc;
            wb_rd   <= rd;
            wb_data <= alu_result;
        end
    end

    // Reported only in run-high cycles so each instruction retires once
    assign retire_valid   = wb_valid && run;
    assign retire_pc      = wb_pc;
    assign retire_wen     = wb_wen;
    assign retire_rd      = wb_rd;
    assign retire_data    = wb_data;
    assign retire_illegal = wb_illegal;

endmodule

// File: fetch/fetch_stage.sv
// ==========================================================================
// Fetch stage
// Keeps the program counter, presents it to instruction memory and
// registers the returned word with its PC for the execute stage.
// A redirect from execute reloads the PC and leaves a bubble behind.
// ==========================================================================

`timescale 1ns/1ns

module fetch_stage (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               run,
    input  logic               redirect,
    input  rv_core_pkg::word_t redirect_pc,
    output rv_core_pkg::word_t imem_addr,
    input  rv_core_pkg::word_t imem_instr,
    output logic               fe_valid,
    output rv_core_pkg::word_t fe_pc,
    output rv_core_pkg::word_t fe_instr
);

    rv_core_pkg::word_t pc;

    // Memory answers in the same cycle
    assign imem_addr = pc;

    // PC and valid bit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc       <= rv_core_pkg::RESET_PC;
            fe_valid <= 1'b0;
        end else if (run) begin
            if (redirect) begin
                // Word fetched this cycle is on the wrong path
                pc       <= redirect_pc;
                fe_valid <= 1'b0;
            end else begin
                pc       <= pc + 32'd4;
                fe_valid <= 1'b1;
            end
        end
    end

    // Payload, qualified by fe_valid downstream
    always_ff @(posedge CLK) begin
        if (run) begin
            fe_pc    <= pc;
            fe_instr <= imem_instr;
        end
    end

endmodule

// File: logic/core_top.sv
// ==========================================================================
// RV32I three-stage core
// Fetch, execute and registered writeback. Same-cycle instruction memory
// port in, retire port out, run freezes the whole pipeline
// ==========================================================================

`timescale 1ns/1ns

module core_top (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  run,
    output rv_core_pkg::word_t    imem_addr,
    input  rv_core_pkg::word_t    imem_instr,
    output logic                  retire_valid,
    output rv_core_pkg::word_t    retire_pc,
    output logic                  retire_wen,
    output rv_core_pkg::reg_idx_t retire_rd,
    output rv_core_pkg::word_t    retire_data,
    output logic                  retire_illegal
);

    // Fetch to execute
    logic               fe_valid;
    rv_core_pkg::word_t fe_pc, fe_instr;

    // Execute back to fetch
    logic               redirect;
    rv_core_pkg::word_t redirect_pc;

    fetch_stage u_fetch (
        .CLK(CLK), .nRST(nRST), .run(run),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .imem_addr(imem_addr), .imem_instr(imem_instr),
        .fe_valid(fe_valid), .fe_pc(fe_pc), .fe_instr(fe_instr)
    );

    execute_stage u_execute (
        .CLK(CLK), .nRST(nRST), .run(run),
        .fe_valid(fe_valid), .fe_pc(fe_pc), .fe_instr(fe_instr),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_wen(retire_wen), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_illegal(retire_illegal)
    );

endmodule

// File: testbench/core_tb_program.svh
// ==========================================================================
// RV32I test program and expected retirements
// One row per executed instruction, in program order. Taken branches and
// jumps leave gaps in the PC column. Those words are never retired
// ==========================================================================

// Row kinds, one per checked behavior
localparam logic [2:0] K_ALU = 3'd0;
localparam logic [2:0] K_FWD = 3'd1;
localparam logic [2:0] K_BR  = 3'd2;
localparam logic [2:0] K_JMP = 3'd3;
localparam logic [2:0] K_ILL = 3'd4;

typedef struct packed {
    logic [2:0]            kind;
    rv_core_pkg::word_t    pc;
    rv_core_pkg::word_t    instr;
    logic                  wen;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::word_t    data;
    logic                  illegal;
} row_t;

localparam int NUM_ROWS = 32;

// Register state for the branches: x2 = -1, x6 = 15, x8 = 1, x9 = 0
// Columns are kind, pc, instruction word, wen, rd, value, illegal
localparam row_t ROWS [NUM_ROWS] = '{
    '{K_ALU, 32'h00, 32'h123450B7, 1'b1, 5'd1,  32'h12345000, 1'b0},  // lui  x1, 0x12345
    '{K_FWD, 32'h04, 32'h67808093, 1'b1, 5'd1,  32'h12345678, 1'b0},  // addi x1, x1, 0x678
    '{K_ALU, 32'h08, 32'hFFF00113, 1'b1, 5'd2,  32'hFFFFFFFF, 1'b0},  // addi x2, x0, -1
    '{K_FWD, 32'h0C, 32'h002081B3, 1'b1, 5'd3,  32'h12345677, 1'b0},  // add  x3, x1, x2
    '{K_FWD, 32'h10, 32'h40118233, 1'b1, 5'd4,  32'hFFFFFFFF, 1'b0},  // sub  x4, x3, x1
    '{K_ALU, 32'h14, 32'h00409293, 1'b1, 5'd5,  32'h23456780, 1'b0},  // slli x5, x1, 4
    '{K_ALU, 32'h18, 32'h01C15313, 1'b1, 5'd6,  32'h0000000F, 1'b0},  // srli x6, x2, 28
    '{K_ALU, 32'h1C, 32'h40315393, 1'b1, 5'd7,  32'hFFFFFFFF, 1'b0},  // srai x7, x2, 3
    '{K_FWD, 32'h20, 32'h00612433, 1'b1, 5'd8,  32'h00000001, 1'b0},  // slt  x8, x2, x6
    '{K_ALU, 32'h24, 32'h006134B3, 1'b1, 5'd9,  32'h00000000, 1'b0},  // sltu x9, x2, x6
    '{K_ALU, 32'h28, 32'h0050C533, 1'b1, 5'd10, 32'h317131F8, 1'b0},  // xor  x10, x1, x5
    '{K_FWD, 32'h2C, 32'h00508013, 1'b0, 5'd0,  32'h1234567D, 1'b0},  // addi x0, x1, 5
    '{K_FWD, 32'h30, 32'h006005B3, 1'b1, 5'd11, 32'h0000000F, 1'b0},  // add  x11, x0, x6
    '{K_ALU, 32'h34, 32'h0F00F813, 1'b1, 5'd16, 32'h00000070, 1'b0},  // andi x16, x1, 0xf0
    '{K_FWD, 32'h38, 32'h006868B3, 1'b1, 5'd17, 32'h0000007F, 1'b0},  // or   x17, x16, x6
    '{K_BR,  32'h3C, 32'h00940463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // beq  x8, x9 not taken
    '{K_BR,  32'h40, 32'h00048463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // beq  x9, x0 taken
    '{K_BR,  32'h48, 32'h00049463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bne  x9, x0 not taken
    '{K_BR,  32'h4C, 32'h00941463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bne  x8, x9 taken
    '{K_BR,  32'h54, 32'h00234463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // blt  x6, x2 not taken
    '{K_BR,  32'h58, 32'h00614463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // blt  x2, x6 taken
    '{K_BR,  32'h60, 32'h00615463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bge  x2, x6 not taken
    '{K_BR,  32'h64, 32'h00235463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bge  x6, x2 taken
    '{K_BR,  32'h6C, 32'h00616463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bltu x2, x6 not taken
    '{K_BR,  32'h70, 32'h00236463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bltu x6, x2 taken
    '{K_BR,  32'h78, 32'h00237463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgeu x6, x2 not taken
    '{K_BR,  32'h7C, 32'h00617463, 1'b0, 5'd0,  32'h00000000, 1'b0},  // bgeu x2, x6 taken
    '{K_JMP, 32'h84, 32'h00C0066F, 1'b1, 5'd12, 32'h00000088, 1'b0},  // jal  x12, +12
    '{K_JMP, 32'h90, 32'h00000697, 1'b1, 5'd13, 32'h00000090, 1'b0},  // auipc x13, 0
    '{K_JMP, 32'h94, 32'h01968767, 1'b1, 5'd14, 32'h00000098, 1'b0},  // jalr x14, 25(x13)
    '{K_ILL, 32'hA8, 32'h00000000, 1'b0, 5'd0,  32'h00000000, 1'b1},  // all-zero word
    '{K_ILL, 32'hAC, 32'h00170793, 1'b1, 5'd15, 32'h00000099, 1'b0}   // addi x15, x14, 1
};

// File: testbench/core_tb.sv
// ==========================================================================
// Core testbench
// Runs a fixed RV32I program from a same-cycle instruction memory and
// checks every retirement against the expected table, with random
// pipeline freezes between retirements
// ==========================================================================

`timescale 1ns/1ns

module core_tb;

    localparam int          RETIRE_TIMEOUT = 20;
    localparam int          IMEM_WORDS     = 64;
    localparam int unsigned SEED           = 32'h7c5b_a8e6;

    logic                  CLK;
    logic                  nRST;
    logic                  run;
    rv_core_pkg::word_t    imem_addr;
    rv_core_pkg::word_t    imem_instr;
    logic                  retire_valid;
    rv_core_pkg::word_t    retire_pc;
    logic                  retire_wen;
    rv_core_pkg::reg_idx_t retire_rd;
    rv_core_pkg::word_t    retire_data;
    logic                  retire_illegal;

    // Program words and the expected retire sequence
    `include "core_tb_program.svh"

    rv_core_pkg::word_t imem [IMEM_WORDS];
    int checked;
    int mismatches;
    int timeouts;

    core_top UUT (
        .CLK(CLK), .nRST(nRST), .run(run),
        .imem_addr(imem_addr), .imem_instr(imem_instr),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_wen(retire_wen), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_illegal(retire_illegal)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Same-cycle read, upper address bits ignored
    assign imem_instr = imem[imem_addr[7:2]];

    task automatic load_imem();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            // addi x0, x0, index, a NOP tagged with its own word index
            imem[i] = {i[11:0], 20'h00013};
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            imem[ROWS[i].pc[7:2]] = ROWS[i].instr;
        end
    endtask

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            K_ALU:   return "alu";
            K_FWD:   return "forward";
            K_BR:    return "branch";
            K_JMP:   return "jump";
            default: return "illegal";
        endcase
    endfunction

    task automatic check_word(input string name, input rv_core_pkg::word_t expected,
                              input rv_core_pkg::word_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_idx(input string name, input rv_core_pkg::reg_idx_t expected,
                             input rv_core_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected x%0d, actual x%0d", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            mismatches++;
        end
    endtask

    // Freeze for a number of whole cycles, starting at the next edge
    // Nothing may retire while run is low
    task automatic hold_run_low(input int cycles);
        @(posedge CLK);
        run <= 1'b0;
        repeat (cycles) begin
            @(negedge CLK);
            check_bit("frozen retire_valid", 1'b0, retire_valid);
            @(posedge CLK);
        end
        run <= 1'b1;
    endtask

    // Mid-cycle sampling, one look per clock
    task automatic wait_retire(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < RETIRE_TIMEOUT) begin
            @(negedge CLK);
            seen = retire_valid;
            waited++;
        end
    endtask

    task automatic compare_row(input int idx);
        string tag;
        tag = $sformatf("%s[%0d]", kind_name(ROWS[idx].kind), idx);
        check_word({tag, " pc"}, ROWS[idx].pc, retire_pc);
        check_bit({tag, " wen"}, ROWS[idx].wen, retire_wen);
        check_bit({tag, " illegal"}, ROWS[idx].illegal, retire_illegal);
        // Destination and value only mean something for a real write
        if (ROWS[idx].wen) begin
            check_idx({tag, " rd"}, ROWS[idx].rd, retire_rd);
            check_word({tag, " data"}, ROWS[idx].data, retire_data);
        end
        checked++;
    endtask

    initial begin
        int freeze;
        bit seen;
        void'($urandom(SEED));
        checked    = 0;
        mismatches = 0;
        timeouts   = 0;
        nRST       = 1'b0;
        run        = 1'b0;
        load_imem();
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;
        run  <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            // Zero to three frozen cycles before each retirement
            freeze = $urandom % 4;
            if (freeze > 0) begin
                hold_run_low(freeze);
            end
            wait_retire(seen);
            if (!seen) begin
                $display("No retirement for table row %0d within %0d cycles", i,
                         RETIRE_TIMEOUT);
                timeouts++;
                break;
            end
            compare_row(i);
        end
        $display("Retirements checked: %0d, mismatches: %0d, timeouts: %0d",
                 checked, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+testbench
common/rv_core_pkg.sv
logic/reg_file.sv
execute/alu.sv
execute/control_unit.sv
execute/execute_stage.sv
fetch/fetch_stage.sv
logic/core_top.sv
testbench/core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module core_tb -Mdir obj_dir -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/core_tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
